/* hw/csrArchPkg.sv */
`default_nettype none

package csrArchPkg;

    localparam int XLEN   = 32;
    localparam int ADDR_W = 12;

    typedef enum logic [ADDR_W-1:0] {
        CSR_MSTATUS       = 12'h300,
        CSR_MISA          = 12'h301,
        CSR_MIE           = 12'h304,
        CSR_MTVEC         = 12'h305,
        CSR_MCOUNTEREN    = 12'h306,
        CSR_MCOUNTINHIBIT = 12'h320,
        CSR_MSCRATCH      = 12'h340,
        CSR_MEPC          = 12'h341,
        CSR_MCAUSE        = 12'h342,
        CSR_MTVAL         = 12'h343,
        CSR_MIP           = 12'h344,
        CSR_MCYCLE        = 12'hB00,
        CSR_MINSTRET      = 12'hB02,
        CSR_MCYCLEH       = 12'hB80,
        CSR_MINSTRETH     = 12'hB82,
        CSR_CYCLE         = 12'hC00,  // user shadows of the counters
        CSR_INSTRET       = 12'hC02,
        CSR_CYCLEH        = 12'hC80,
        CSR_INSTRETH      = 12'hC82,
        CSR_MVENDORID     = 12'hF11,
        CSR_MARCHID       = 12'hF12,
        CSR_MIMPID        = 12'hF13,
        CSR_MHARTID       = 12'hF14
    } CsrAddr;

    typedef enum logic [1:0] {
        U = 2'd0,
        M = 2'd3
    } PrivLevel;

    typedef enum logic [4:0] {
        INSTR_MISALIGNED = 5'd0,
        INSTR_FAULT      = 5'd1,
        ILLEGAL_INSTR    = 5'd2,
        BREAKPOINT       = 5'd3,
        LOAD_MISALIGNED  = 5'd4,
        LOAD_FAULT       = 5'd5,
        STORE_MISALIGNED = 5'd6,
        STORE_FAULT      = 5'd7,
        ECALL_U          = 5'd8,
        ECALL_M          = 5'd11
    } TrapCause;

    // interrupt codes reuse exception values, told apart by mcause[31]
    localparam TrapCause MTI = STORE_FAULT;
    localparam TrapCause MEI = ECALL_M;

    typedef struct packed {
        logic [18:0] rsvdHi;   // 31..13
        PrivLevel    mpp;
        logic [2:0]  rsvdMid;  // vs, spp
        logic        mpie;
        logic [2:0]  rsvdIe;
        logic        mie;
        logic [2:0]  rsvdLo;
    } MStatus;

    localparam logic [XLEN-1:0] RESET_VECTOR  = 32'h8000_0000;
    localparam logic [XLEN-1:0] MISA_VALUE    = 32'h4010_1100;  // rv32 i m u
    localparam logic [XLEN-1:0] MARCHID_VALUE = 32'h0000_0021;
    localparam logic [XLEN-1:0] MIMPID_VALUE  = 32'h0000_0001;

    localparam logic [XLEN-1:0] IRQ_MASK = 32'h0000_0880;  // mti and mei
    localparam logic [XLEN-1:0] CNT_MASK = 32'h0000_0005;  // cycle and instret

endpackage

`default_nettype wire

/* hw/csrUnitPkg.sv */
`default_nettype none

package csrUnitPkg;

    localparam int TAG_W = 7;

    typedef enum logic [2:0] {
        READ,
        RW,
        RS,
        RC,
        RWI,
        RSI,
        RCI,
        MRET
    } CsrOp;

    typedef enum logic [1:0] {
        NONE,
        ILLEGAL,
        XRET,
        ORDERING  // later instructions must see the new value
    } ResultFlags;

    typedef struct packed {
        logic                              valid;
        CsrOp                              op;
        logic [csrArchPkg::ADDR_W-1:0]     addr;  // may hold unknown addresses
        logic [4:0]                        uimm;
        logic [csrArchPkg::XLEN-1:0]       srcA;
        logic [TAG_W-1:0]                  tag;
    } CsrReq;

    typedef struct packed {
        logic                              valid;
        logic [TAG_W-1:0]                  tag;
        logic [csrArchPkg::XLEN-1:0]       data;
        ResultFlags                        flags;
    } CsrResult;

    typedef struct packed {
        logic                              valid;
        logic                              isInterrupt;
        csrArchPkg::TrapCause              cause;
        logic [csrArchPkg::XLEN-1:0]       pc;
        logic [csrArchPkg::XLEN-1:0]       tval;
    } TrapInfo;

    typedef struct packed {
        logic                              valid;
        logic [csrArchPkg::ADDR_W-1:0]     addr;
        logic [csrArchPkg::XLEN-1:0]       data;
    } CsrWrite;

endpackage

`default_nettype wire

/* hw/csrExec.sv */
`default_nettype none

module csrExec (
    input  wire                          clk,
    input  wire                          rst,
    input  wire csrUnitPkg::CsrReq       req,
    input  wire csrArchPkg::PrivLevel    priv,
    input  wire [csrArchPkg::XLEN-1:0]   rdata,
    input  wire                          addrKnown,
    output csrUnitPkg::CsrWrite          wr,
    output logic                         mret,
    output csrUnitPkg::CsrResult         result
);

    logic                        isMret;
    logic                        isWrite;
    logic                        cntDenied;
    logic                        illegal;
    logic                        ordering;
    logic [csrArchPkg::XLEN-1:0] operand;
    logic [csrArchPkg::XLEN-1:0] wdata;
    logic [1:0]                  cntEn;  // copy of mcounteren bits 2 and 0
    csrUnitPkg::ResultFlags      flags;

    assign isMret  = req.op == csrUnitPkg::MRET;
    assign isWrite = !isMret && req.op != csrUnitPkg::READ;

    // user access to the counter shadows
    always_comb begin
        cntDenied = 1'b0;
        if (priv == csrArchPkg::U) begin
            if (req.addr inside {csrArchPkg::CSR_CYCLE, csrArchPkg::CSR_CYCLEH})
                cntDenied = !cntEn[0];
            if (req.addr inside {csrArchPkg::CSR_INSTRET, csrArchPkg::CSR_INSTRETH})
                cntDenied = !cntEn[1];
        end
    end

    always_comb begin
        if (isMret)
            illegal = priv != csrArchPkg::M;
        else
            illegal = priv < req.addr[9:8] || !addrKnown
                || (isWrite && &req.addr[11:10]) || cntDenied;  // 11 = read only
    end

    assign operand = (req.op inside {csrUnitPkg::RWI, csrUnitPkg::RSI, csrUnitPkg::RCI})
        ? {{(csrArchPkg::XLEN - 5){1'b0}}, req.uimm} : req.srcA;

    always_comb begin
        case (req.op)
            csrUnitPkg::RS, csrUnitPkg::RSI: wdata = rdata | operand;
            csrUnitPkg::RC, csrUnitPkg::RCI: wdata = rdata & ~operand;
            default:                         wdata = operand;
        endcase
    end

    assign ordering = isWrite && req.addr inside {csrArchPkg::CSR_MSTATUS,
        csrArchPkg::CSR_MIE, csrArchPkg::CSR_MCOUNTEREN};

    always_comb begin
        if (illegal)
            flags = csrUnitPkg::ILLEGAL;
        else if (isMret)
            flags = csrUnitPkg::XRET;
        else if (ordering)
            flags = csrUnitPkg::ORDERING;
        else
            flags = csrUnitPkg::NONE;
    end

    assign wr = '{valid: req.valid && isWrite && !illegal, addr: req.addr, data: wdata};
    assign mret = req.valid && isMret && !illegal;

    always_ff @(posedge clk) begin
        if (rst) begin
            result.valid <= 1'b0;
            cntEn <= 2'b00;
        end else begin
            result.valid <= req.valid;
            result.tag <= req.tag;
            result.data <= isMret ? {csrArchPkg::XLEN{1'b0}} : rdata;  // old value
            result.flags <= flags;
            if (wr.valid && wr.addr == csrArchPkg::CSR_MCOUNTEREN)
                cntEn <= {wdata[2], wdata[0]};
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(wr.valid && mret))
        else $error("csr write and mret in the same cycle");

endmodule

`default_nettype wire

/* hw/csrRegFile.sv */
`default_nettype none

module csrRegFile (
    input  wire                              clk,
    input  wire                              rst,
    input  wire [csrArchPkg::ADDR_W-1:0]     addr,
    input  wire csrUnitPkg::CsrWrite         wr,
    input  wire csrUnitPkg::TrapInfo         trap,
    input  wire csrArchPkg::MStatus          mstatus,
    input  wire                              irq,
    input  wire [63:0]                       mtime,
    input  wire [63:0]                       mtimecmp,
    input  wire [1:0]                        retireCount,
    output logic [csrArchPkg::XLEN-1:0]      rdata,
    output logic                             addrKnown,
    output logic [csrArchPkg::XLEN-1:0]      mie,
    output logic [csrArchPkg::XLEN-1:0]      mip,
    output logic [csrArchPkg::XLEN-1:0]      mepc,
    output logic [csrArchPkg::XLEN-1:0]      mtvec
);

    logic [csrArchPkg::XLEN-1:0] mscratch;
    logic [csrArchPkg::XLEN-1:0] mcause;
    logic [csrArchPkg::XLEN-1:0] mtval;
    logic [csrArchPkg::XLEN-1:0] mcounteren;
    logic [csrArchPkg::XLEN-1:0] mcountinhibit;
    logic [csrArchPkg::XLEN-1:0] tvalSel;
    logic [63:0]                 mcycle;
    logic [63:0]                 minstret;

    always_comb begin
        addrKnown = 1'b1;
        rdata = '0;
        case (addr)
            csrArchPkg::CSR_MSTATUS:       rdata = mstatus;
            csrArchPkg::CSR_MISA:          rdata = csrArchPkg::MISA_VALUE;
            csrArchPkg::CSR_MIE:           rdata = mie;
            csrArchPkg::CSR_MTVEC:         rdata = mtvec;
            csrArchPkg::CSR_MCOUNTEREN:    rdata = mcounteren;
            csrArchPkg::CSR_MCOUNTINHIBIT: rdata = mcountinhibit;
            csrArchPkg::CSR_MSCRATCH:      rdata = mscratch;
            csrArchPkg::CSR_MEPC:          rdata = mepc;
            csrArchPkg::CSR_MCAUSE:        rdata = mcause;
            csrArchPkg::CSR_MTVAL:         rdata = mtval;
            csrArchPkg::CSR_MIP:           rdata = mip;
            csrArchPkg::CSR_MCYCLE,
            csrArchPkg::CSR_CYCLE:         rdata = mcycle[31:0];
            csrArchPkg::CSR_MCYCLEH,
            csrArchPkg::CSR_CYCLEH:        rdata = mcycle[63:32];
            csrArchPkg::CSR_MINSTRET,
            csrArchPkg::CSR_INSTRET:       rdata = minstret[31:0];
            csrArchPkg::CSR_MINSTRETH,
            csrArchPkg::CSR_INSTRETH:      rdata = minstret[63:32];
            csrArchPkg::CSR_MARCHID:       rdata = csrArchPkg::MARCHID_VALUE;
            csrArchPkg::CSR_MIMPID:        rdata = csrArchPkg::MIMPID_VALUE;
            csrArchPkg::CSR_MVENDORID,
            csrArchPkg::CSR_MHARTID:       rdata = '0;
            default:                       addrKnown = 1'b0;
        endcase
    end

    // mtval only carries an address for fault and misaligned traps
    always_comb begin
        tvalSel = '0;
        if (!trap.isInterrupt) begin
            case (trap.cause)
                csrArchPkg::INSTR_MISALIGNED, csrArchPkg::INSTR_FAULT,
                csrArchPkg::LOAD_MISALIGNED, csrArchPkg::LOAD_FAULT,
                csrArchPkg::STORE_MISALIGNED, csrArchPkg::STORE_FAULT: tvalSel = trap.tval;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (trap.valid) begin
            mepc <= trap.pc;
            mtval <= tvalSel;
        end else if (wr.valid) begin
            case (wr.addr)
                csrArchPkg::CSR_MSCRATCH: mscratch <= wr.data;
                csrArchPkg::CSR_MEPC:     mepc <= {wr.data[31:1], 1'b0};
                csrArchPkg::CSR_MTVAL:    mtval <= wr.data;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mie <= '0;
            mip <= '0;
            mtvec <= csrArchPkg::RESET_VECTOR;
            mcause <= '0;
            mcounteren <= '0;
            mcountinhibit <= '0;
        end else begin
            mip <= '0;
            mip[7] <= mtime >= mtimecmp;
            mip[11] <= irq;
            if (trap.valid)
                mcause <= {trap.isInterrupt, 26'b0, trap.cause};
            else if (wr.valid) begin
                case (wr.addr)
                    csrArchPkg::CSR_MIE:           mie <= wr.data & csrArchPkg::IRQ_MASK;
                    csrArchPkg::CSR_MTVEC:         mtvec <= {wr.data[31:2], 2'b00};  // direct
                    csrArchPkg::CSR_MCAUSE:        mcause <= {wr.data[31], 26'b0, wr.data[4:0]};
                    csrArchPkg::CSR_MCOUNTEREN:    mcounteren <= wr.data & csrArchPkg::CNT_MASK;
                    csrArchPkg::CSR_MCOUNTINHIBIT: mcountinhibit <= wr.data & csrArchPkg::CNT_MASK;
                    default: ;
                endcase
            end
        end
    end

    // explicit writes win over counting
    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle <= '0;
            minstret <= '0;
        end else begin
            if (wr.valid && wr.addr == csrArchPkg::CSR_MCYCLE)
                mcycle[31:0] <= wr.data;
            else if (wr.valid && wr.addr == csrArchPkg::CSR_MCYCLEH)
                mcycle[63:32] <= wr.data;
            else if (!mcountinhibit[0])
                mcycle <= mcycle + 64'd1;

            if (wr.valid && wr.addr == csrArchPkg::CSR_MINSTRET)
                minstret[31:0] <= wr.data;
            else if (wr.valid && wr.addr == csrArchPkg::CSR_MINSTRETH)
                minstret[63:32] <= wr.data;
            else if (!mcountinhibit[2])
                minstret <= minstret + {62'd0, retireCount};
        end
    end

    assert property (@(posedge clk) disable iff (rst) (mip & ~csrArchPkg::IRQ_MASK) == '0)
        else $error("mip holds bits other than mtip and meip");

endmodule

`default_nettype wire

/* hw/trapCtrl.sv */
`default_nettype none

module trapCtrl (
    input  wire                              clk,
    input  wire                              rst,
    input  wire csrUnitPkg::TrapInfo         trap,
    input  wire csrUnitPkg::CsrWrite         wr,
    input  wire                              mret,
    input  wire [csrArchPkg::XLEN-1:0]       mie,
    input  wire [csrArchPkg::XLEN-1:0]       mip,
    input  wire [csrArchPkg::XLEN-1:0]       mepc,
    output csrArchPkg::PrivLevel             priv,
    output csrArchPkg::MStatus               mstatus,
    output logic [csrArchPkg::XLEN-1:0]      retvec,
    output logic                             interruptPending,
    output csrArchPkg::TrapCause             interruptCause
);

    csrArchPkg::MStatus          wrStatus;
    logic [csrArchPkg::XLEN-1:0] pendingBits;

    assign wrStatus = wr.data;

    always_ff @(posedge clk) begin
        if (rst) begin
            priv <= csrArchPkg::M;
            mstatus <= '0;
        end else if (trap.valid) begin
            mstatus.mpie <= mstatus.mie;
            mstatus.mie <= 1'b0;
            mstatus.mpp <= priv;
            priv <= csrArchPkg::M;
        end else if (mret) begin
            priv <= mstatus.mpp;
            mstatus.mie <= mstatus.mpie;
            mstatus.mpie <= 1'b1;
            mstatus.mpp <= csrArchPkg::U;
        end else if (wr.valid && wr.addr == csrArchPkg::CSR_MSTATUS) begin
            mstatus.mie <= wrStatus.mie;
            mstatus.mpie <= wrStatus.mpie;
            // only U and M exist, anything else lands in U
            mstatus.mpp <= (wrStatus.mpp == csrArchPkg::M) ? csrArchPkg::M : csrArchPkg::U;
        end
    end

    always_ff @(posedge clk) begin
        if (mret)
            retvec <= mepc;
    end

    assign pendingBits = mip & mie & csrArchPkg::IRQ_MASK;
    assign interruptPending = |pendingBits && (priv == csrArchPkg::U || mstatus.mie);
    assign interruptCause = pendingBits[11] ? csrArchPkg::MEI : csrArchPkg::MTI;  // mei first

    // the pipeline never issues a csr op alongside a trap
    assert property (@(posedge clk) disable iff (rst) trap.valid |-> !(mret || wr.valid))
        else $error("trap coincides with a csr request");

    assert property (@(posedge clk) disable iff (rst)
        priv inside {csrArchPkg::U, csrArchPkg::M})
        else $error("priv left U and M");

endmodule

`default_nettype wire

/* hw/csrUnit.sv */
`default_nettype none

module csrUnit (
    input  wire                              clk,
    input  wire                              rst,
    input  wire csrUnitPkg::CsrReq           req,
    input  wire csrUnitPkg::TrapInfo         trap,
    input  wire                              irq,
    input  wire [63:0]                       mtime,
    input  wire [63:0]                       mtimecmp,
    input  wire [1:0]                        retireCount,
    output csrUnitPkg::CsrResult             result,
    output csrArchPkg::PrivLevel             priv,
    output logic                             interruptPending,
    output csrArchPkg::TrapCause             interruptCause,
    output logic [csrArchPkg::XLEN-1:0]      mtvec,
    output logic [csrArchPkg::XLEN-1:0]      retvec
);

    logic [csrArchPkg::XLEN-1:0] rdata;
    logic                        addrKnown;
    csrUnitPkg::CsrWrite         wr;
    logic                        mret;
    csrArchPkg::MStatus          mstatus;
    logic [csrArchPkg::XLEN-1:0] mie;
    logic [csrArchPkg::XLEN-1:0] mip;
    logic [csrArchPkg::XLEN-1:0] mepc;

    csrExec i_exec (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .priv      (priv),
        .rdata     (rdata),
        .addrKnown (addrKnown),
        .wr        (wr),
        .mret      (mret),
        .result    (result)
    );

    csrRegFile i_regFile (
        .clk         (clk),
        .rst         (rst),
        .addr        (req.addr),  // read port follows the live request
        .wr          (wr),
        .trap        (trap),
        .mstatus     (mstatus),
        .irq         (irq),
        .mtime       (mtime),
        .mtimecmp    (mtimecmp),
        .retireCount (retireCount),
        .rdata       (rdata),
        .addrKnown   (addrKnown),
        .mie         (mie),
        .mip         (mip),
        .mepc        (mepc),
        .mtvec       (mtvec)
    );

    trapCtrl i_trapCtrl (
        .clk              (clk),
        .rst              (rst),
        .trap             (trap),
        .wr               (wr),
        .mret             (mret),
        .mie              (mie),
        .mip              (mip),
        .mepc             (mepc),
        .priv             (priv),
        .mstatus          (mstatus),
        .retvec           (retvec),
        .interruptPending (interruptPending),
        .interruptCause   (interruptCause)
    );

endmodule

`default_nettype wire

/* test/csrUnitChecks.sv */
`default_nettype none

module csrUnitChecks (
    input  wire                              clk,
    input  wire                              rst,
    input  wire csrUnitPkg::CsrReq           req,
    input  wire csrUnitPkg::TrapInfo         trap,
    input  wire                              irq,
    input  wire [63:0]                       mtime,
    input  wire [63:0]                       mtimecmp,
    input  wire [1:0]                        retireCount,
    input  wire csrUnitPkg::CsrResult        result,
    input  wire csrArchPkg::PrivLevel        priv,
    input  wire                              interruptPending,
    input  wire csrArchPkg::TrapCause        interruptCause,
    input  wire [31:0]                       mtvec,
    input  wire [31:0]                       retvec,
    output logic                             failed
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [1:0]  mPriv;
    logic        sMie;
    logic        sMpie;
    logic [1:0]  sMpp;
    logic [31:0] mScratch, mTvec, mIe, mCntEn, mInhibit, mEpc, mCause, mTval, mIp, mRetvec;
    logic [63:0] mCycle, mInstret;
    logic        scratchSet, retvecSet;
    logic        expValid, expCheck;
    logic [6:0]  expTag;
    logic [31:0] expData;
    logic [1:0]  expFlags;
    logic [31:0] oldVal, opnd, newVal, pend;
    logic        known, isWr, isMret, denied, illegal, expPending;
    logic [1:0]  flags;
    logic [4:0]  expCause;

    initial failed = 1'b0;

    task automatic reportFail(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        failed = 1'b1;
    endtask

    always_comb begin
        known = 1'b1;
        oldVal = '0;
        case (req.addr)
            csrArchPkg::CSR_MSTATUS:       oldVal = {19'b0, sMpp, 3'b0, sMpie, 3'b0, sMie, 3'b0};
            csrArchPkg::CSR_MISA:          oldVal = csrArchPkg::MISA_VALUE;
            csrArchPkg::CSR_MIE:           oldVal = mIe;
            csrArchPkg::CSR_MTVEC:         oldVal = mTvec;
            csrArchPkg::CSR_MCOUNTEREN:    oldVal = mCntEn;
            csrArchPkg::CSR_MCOUNTINHIBIT: oldVal = mInhibit;
            csrArchPkg::CSR_MSCRATCH:      oldVal = mScratch;
            csrArchPkg::CSR_MEPC:          oldVal = mEpc;
            csrArchPkg::CSR_MCAUSE:        oldVal = mCause;
            csrArchPkg::CSR_MTVAL:         oldVal = mTval;
            csrArchPkg::CSR_MIP:           oldVal = mIp;
            csrArchPkg::CSR_MCYCLE, csrArchPkg::CSR_CYCLE:       oldVal = mCycle[31:0];
            csrArchPkg::CSR_MCYCLEH, csrArchPkg::CSR_CYCLEH:     oldVal = mCycle[63:32];
            csrArchPkg::CSR_MINSTRET, csrArchPkg::CSR_INSTRET:   oldVal = mInstret[31:0];
            csrArchPkg::CSR_MINSTRETH, csrArchPkg::CSR_INSTRETH: oldVal = mInstret[63:32];
            csrArchPkg::CSR_MARCHID:       oldVal = csrArchPkg::MARCHID_VALUE;
            csrArchPkg::CSR_MIMPID:        oldVal = csrArchPkg::MIMPID_VALUE;
            csrArchPkg::CSR_MVENDORID, csrArchPkg::CSR_MHARTID: oldVal = '0;
            default:                       known = 1'b0;
        endcase
    end

    always_comb begin
        isMret = req.op == csrUnitPkg::MRET;
        isWr = !isMret && req.op != csrUnitPkg::READ;
        denied = mPriv == 2'd0 && (
            (req.addr inside {csrArchPkg::CSR_CYCLE, csrArchPkg::CSR_CYCLEH} && !mCntEn[0])
            || (req.addr inside {csrArchPkg::CSR_INSTRET, csrArchPkg::CSR_INSTRETH} && !mCntEn[2]));
        if (isMret)
            illegal = mPriv != 2'd3;
        else
            illegal = mPriv < req.addr[9:8] || !known
                || (isWr && req.addr[11:10] == 2'b11) || denied;
        opnd = (req.op inside {csrUnitPkg::RWI, csrUnitPkg::RSI, csrUnitPkg::RCI})
            ? {27'b0, req.uimm} : req.srcA;
        if (req.op inside {csrUnitPkg::RS, csrUnitPkg::RSI})
            newVal = oldVal | opnd;
        else if (req.op inside {csrUnitPkg::RC, csrUnitPkg::RCI})
            newVal = oldVal & ~opnd;
        else
            newVal = opnd;
        if (illegal)
            flags = csrUnitPkg::ILLEGAL;
        else if (isMret)
            flags = csrUnitPkg::XRET;
        else if (isWr && req.addr inside {csrArchPkg::CSR_MSTATUS, csrArchPkg::CSR_MIE,
                csrArchPkg::CSR_MCOUNTEREN})
            flags = csrUnitPkg::ORDERING;
        else
            flags = csrUnitPkg::NONE;
        pend = mIp & mIe & csrArchPkg::IRQ_MASK;
        expPending = |pend && (mPriv == 2'd0 || sMie);
        expCause = pend[11] ? 5'd11 : 5'd7;  // external wins
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mPriv <= 2'd3;
            sMie <= 1'b0;
            sMpie <= 1'b0;
            sMpp <= 2'd0;
            mIe <= '0;
            mIp <= '0;
            mTvec <= csrArchPkg::RESET_VECTOR;
            mCntEn <= '0;
            mInhibit <= '0;
            mCause <= '0;
            mScratch <= '0;
            mCycle <= '0;
            mInstret <= '0;
            expValid <= 1'b0;
            scratchSet <= 1'b0;
            retvecSet <= 1'b0;
        end else begin
            expValid <= req.valid;
            expTag <= req.tag;
            expData <= oldVal;
            expFlags <= flags;
            expCheck <= !illegal && !isMret
                && !(req.addr == csrArchPkg::CSR_MSCRATCH && !scratchSet);  // unset scratch
            mIp <= {20'b0, irq, 3'b0, mtime >= mtimecmp, 7'b0};
            if (!mInhibit[0])
                mCycle <= mCycle + 64'd1;
            if (!mInhibit[2])
                mInstret <= mInstret + {62'd0, retireCount};
            if (trap.valid) begin
                mEpc <= trap.pc;
                mCause <= {trap.isInterrupt, 26'b0, trap.cause};
                mTval <= (!trap.isInterrupt && trap.cause inside {5'd0, 5'd1, 5'd4, 5'd5,
                    5'd6, 5'd7}) ? trap.tval : 32'd0;
                sMpie <= sMie;
                sMie <= 1'b0;
                sMpp <= mPriv;
                mPriv <= 2'd3;
            end else if (req.valid && !illegal && isMret) begin
                mPriv <= sMpp;
                sMie <= sMpie;
                sMpie <= 1'b1;
                sMpp <= 2'd0;
                mRetvec <= mEpc;
                retvecSet <= 1'b1;
            end else if (req.valid && !illegal && isWr) begin
                case (req.addr)
                    csrArchPkg::CSR_MSTATUS: begin
                        sMie <= newVal[3];
                        sMpie <= newVal[7];
                        sMpp <= (newVal[12:11] == 2'd3) ? 2'd3 : 2'd0;
                    end
                    csrArchPkg::CSR_MIE:           mIe <= newVal & csrArchPkg::IRQ_MASK;
                    csrArchPkg::CSR_MTVEC:         mTvec <= {newVal[31:2], 2'b00};
                    csrArchPkg::CSR_MCOUNTEREN:    mCntEn <= newVal & 32'h5;
                    csrArchPkg::CSR_MCOUNTINHIBIT: mInhibit <= newVal & 32'h5;
                    csrArchPkg::CSR_MSCRATCH: begin
                        mScratch <= newVal;
                        scratchSet <= 1'b1;
                    end
                    csrArchPkg::CSR_MEPC:          mEpc <= {newVal[31:1], 1'b0};
                    csrArchPkg::CSR_MCAUSE:        mCause <= {newVal[31], 26'b0, newVal[4:0]};
                    csrArchPkg::CSR_MTVAL:         mTval <= newVal;
                    default: ;
                endcase
            end
        end
    end

    assert property (@(posedge clk) $past(rst) && !rst |-> !result.valid
        && priv == csrArchPkg::M && !interruptPending && mtvec == csrArchPkg::RESET_VECTOR)
        else reportFail("state after reset is wrong");
    assert property (@(posedge clk) disable iff (rst) result.valid == expValid)
        else reportFail("result.valid does not follow the request");
    assert property (@(posedge clk) disable iff (rst) expValid |-> result.tag == expTag
        && result.flags == expFlags && (!expCheck || result.data == expData))
        else reportFail($sformatf("result mismatch, got %h/%0d want %h/%0d",
            result.data, result.flags, expData, expFlags));
    assert property (@(posedge clk) disable iff (rst) priv == mPriv)
        else reportFail($sformatf("priv is %0d, want %0d", priv, mPriv));
    assert property (@(posedge clk) disable iff (rst) mtvec == mTvec)
        else reportFail($sformatf("mtvec is %h, want %h", mtvec, mTvec));
    assert property (@(posedge clk) disable iff (rst) interruptPending == expPending
        && (!expPending || interruptCause == expCause))
        else reportFail($sformatf("interrupt %0d/%0d, want %0d/%0d",
            interruptPending, interruptCause, expPending, expCause));
    assert property (@(posedge clk) disable iff (rst) retvecSet |-> retvec == mRetvec)
        else reportFail($sformatf("retvec is %h, want %h", retvec, mRetvec));

endmodule

`default_nettype wire

/* test/csrUnitTb.sv */
`default_nettype none

module csrUnitTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEQ_CYCLES  = 107;  // clock edges from time zero to the final check
    localparam int CYCLE_LIMIT = 2 * SEQ_CYCLES;

    logic                     clk;
    logic                     rst;
    csrUnitPkg::CsrReq        req;
    csrUnitPkg::TrapInfo      trap;
    logic                     irq;
    logic [63:0]              mtime;
    logic [63:0]              mtimecmp;
    logic [1:0]               retireCount;
    csrUnitPkg::CsrResult     result;
    csrArchPkg::PrivLevel     priv;
    logic                     interruptPending;
    csrArchPkg::TrapCause     interruptCause;
    logic [31:0]              mtvec;
    logic [31:0]              retvec;
    logic                     failed;
    int                       seed;
    int                       cycles = 0;
    logic [11:0]              addrs [3];

    csrUnit i_dut (.*);

    csrUnitChecks i_checks (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("tests failed");
            $fatal(1, "timeout, run passed %0d cycles", CYCLE_LIMIT);
        end
    end

    always @(posedge failed) begin
        $display("tests failed");
        $fatal(1, "a check on the DUT outputs failed");
    end

    // called on a falling edge, returns on the next one
    task automatic issue(input csrUnitPkg::CsrOp op, input logic [11:0] addr,
            input logic [31:0] src);
        req.valid = 1'b1;
        req.op = op;
        req.addr = addr;
        req.srcA = src;
        req.uimm = src[4:0];
        req.tag = req.tag + 7'd1;
        @(negedge clk);
        req.valid = 1'b0;
    endtask

    task automatic raiseTrap(input csrArchPkg::TrapCause cause, input logic [31:0] pc,
            input logic [31:0] tval);
        trap = '{valid: 1'b1, isInterrupt: 1'b0, cause: cause, pc: pc, tval: tval};
        @(negedge clk);
        trap.valid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    initial begin
        int r;
        int opSel;
        int idx;
        addrs = '{csrArchPkg::CSR_MSCRATCH, csrArchPkg::CSR_MTVEC, csrArchPkg::CSR_MIE};
        seed = 1704;
        req = '0;
        trap = '0;
        irq = 1'b0;
        mtime = '0;
        mtimecmp = '1;
        retireCount = 2'd0;
        rst = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        idle(2);

        // trap from M fills mepc, mcause and mtval
        raiseTrap(csrArchPkg::LOAD_FAULT, $random(seed), $random(seed));
        issue(csrUnitPkg::READ, csrArchPkg::CSR_MEPC, 0);
        issue(csrUnitPkg::READ, csrArchPkg::CSR_MCAUSE, 0);
        issue(csrUnitPkg::READ, csrArchPkg::CSR_MTVAL, 0);
        raiseTrap(csrArchPkg::ECALL_M, $random(seed), $random(seed));
        issue(csrUnitPkg::READ, csrArchPkg::CSR_MTVAL, 0);
        issue(csrUnitPkg::RW, csrArchPkg::CSR_MSCRATCH, $random(seed));

        repeat (32) begin
            r = $random(seed);
            opSel = $unsigned(r) % 7;
            idx = ($unsigned(r) >> 8) % 3;
            issue(csrUnitPkg::CsrOp'(opSel[2:0]), addrs[idx], $random(seed));
        end

        issue(csrUnitPkg::RW, csrArchPkg::CSR_MISA, 32'hFFFF_FFFF);
        issue(csrUnitPkg::RS, csrArchPkg::CSR_MHARTID, 32'h1);
        issue(csrUnitPkg::READ, 12'h7C0, 0);  // unknown address

        // drop to U through mret
        issue(csrUnitPkg::RC, csrArchPkg::CSR_MSTATUS, 32'h1800);
        issue(csrUnitPkg::RW, csrArchPkg::CSR_MEPC, 32'h1000_0004);
        issue(csrUnitPkg::MRET, 12'h000, 0);
        issue(csrUnitPkg::READ, csrArchPkg::CSR_MSCRATCH, 0);
        issue(csrUnitPkg::RW, csrArchPkg::CSR_MSCRATCH, 32'h5);
        issue(csrUnitPkg::READ, csrArchPkg::CSR_CYCLE, 0);
        issue(csrUnitPkg::MRET, 12'h000, 0);
        raiseTrap(csrArchPkg::ECALL_U, $random(seed), $random(seed));
        issue(csrUnitPkg::READ, csrArchPkg::CSR_MEPC, 0);
        issue(csrUnitPkg::READ, csrArchPkg::CSR_MCAUSE, 0);
        issue(csrUnitPkg::RS, csrArchPkg::CSR_MCOUNTEREN, 32'h1);
        issue(csrUnitPkg::MRET, 12'h000, 0);
        issue(csrUnitPkg::READ, csrArchPkg::CSR_CYCLE, 0);
        issue(csrUnitPkg::READ, csrArchPkg::CSR_CYCLEH, 0);
        issue(csrUnitPkg::READ, csrArchPkg::CSR_INSTRET, 0);  // still gated
        raiseTrap(csrArchPkg::BREAKPOINT, $random(seed), $random(seed));
        issue(csrUnitPkg::READ, csrArchPkg::CSR_MSCRATCH, 0);  // user write left no trace

        issue(csrUnitPkg::READ, csrArchPkg::CSR_MCYCLE, 0);
        issue(csrUnitPkg::READ, csrArchPkg::CSR_MCYCLE, 0);
        issue(csrUnitPkg::RW, csrArchPkg::CSR_MCOUNTINHIBIT, 32'h1);
        issue(csrUnitPkg::READ, csrArchPkg::CSR_MCYCLE, 0);
        issue(csrUnitPkg::READ, csrArchPkg::CSR_MCYCLE, 0);
        issue(csrUnitPkg::RW, csrArchPkg::CSR_MCOUNTINHIBIT, 32'h0);
        repeat (12) begin
            r = $random(seed);
            retireCount = r[1:0];
            @(negedge clk);
        end
        retireCount = 2'd0;
        issue(csrUnitPkg::READ, csrArchPkg::CSR_MINSTRET, 0);
        issue(csrUnitPkg::READ, csrArchPkg::CSR_MINSTRETH, 0);

        // external interrupt first then timer then both
        issue(csrUnitPkg::RW, csrArchPkg::CSR_MIE, csrArchPkg::IRQ_MASK);
        issue(csrUnitPkg::RS, csrArchPkg::CSR_MSTATUS, 32'h8);
        irq = 1'b1;
        idle(3);
        issue(csrUnitPkg::READ, csrArchPkg::CSR_MIP, 0);
        irq = 1'b0;
        idle(2);
        mtime = 64'd500;
        mtimecmp = 64'd500;
        idle(3);
        irq = 1'b1;
        idle(3);
        issue(csrUnitPkg::RC, csrArchPkg::CSR_MSTATUS, 32'h8);
        idle(3);
        irq = 1'b0;
        mtimecmp = '1;
        idle(3);

        if (failed) begin
            $display("tests failed");
            $fatal(1, "a check on the DUT outputs failed");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
hw/csrArchPkg.sv
hw/csrUnitPkg.sv
hw/csrExec.sv
hw/csrRegFile.sv
hw/trapCtrl.sv
hw/csrUnit.sv
test/csrUnitChecks.sv
test/csrUnitTb.sv

/* Makefile */
SRCS := $(shell grep -v '^+' verilog.f)

obj_dir/VcsrUnitTb: verilog.f $(SRCS)
	verilator --binary --assert --top-module csrUnitTb -f verilog.f -o VcsrUnitTb

run: obj_dir/VcsrUnitTb
	./obj_dir/VcsrUnitTb

clean:
	rm -rf obj_dir

.PHONY: run clean
